//--- design/savestate_pkg.sv
`default_nettype none

package savestate_pkg;

  // Savestate size in 16-bit SD words
  localparam logic [31:0] SS_WORDS16 = 32'd16;

  // Same state in 32-bit bus words, also the core register count
  localparam logic [31:0] SS_WORDS32 = 32'd8;

  // Words per SD block access
  localparam logic [31:0] BLOCK_WORDS = 32'd32;

  localparam logic [31:0] SD_ADDR_W   = 32'd8;
  localparam logic [31:0] CORE_ADDR_W = 32'd3;

  // Transfer controller states
  localparam logic [31:0] CTRL_ST_W = 32'd2;
  localparam logic [1:0] CTRL_IDLE       = 2'd0;
  localparam logic [1:0] CTRL_WAIT_READY = 2'd1;
  localparam logic [1:0] CTRL_WRITING    = 2'd2;
  localparam logic [1:0] CTRL_READING    = 2'd3;

  // Copy engine states
  localparam logic [31:0] ENG_ST_W = 32'd3;
  localparam logic [2:0] ENG_IDLE        = 3'd0;
  localparam logic [2:0] ENG_CREATE_WAIT = 3'd1;
  localparam logic [2:0] ENG_CREATE      = 3'd2;
  localparam logic [2:0] ENG_CREATE_END  = 3'd3;
  localparam logic [2:0] ENG_LOAD        = 3'd4;

  // Low half is the earlier SD word
  typedef struct packed {
    logic [15:0] hi;
    logic [15:0] lo;
  } ss_halves_t;

  typedef union packed {
    logic [31:0] full;
    ss_halves_t  halves;
  } ss_word_u;

endpackage

`default_nettype wire

//--- design/sd_load_packer.sv
`timescale 1ns/1ps
`default_nettype none

module sd_load_packer (
  input  wire                                   clk,
  input  wire                                   reset,
  input  wire                                   load_active,
  input  wire                                   sd_buff_wr,
  input  wire [savestate_pkg::SD_ADDR_W-1:0]    sd_buff_addr,
  input  wire [15:0]                            sd_buff_dout,
  input  wire                                   req_read,
  output logic                                  data_ready,
  output logic [31:0]                           bus_in
);

  logic [$clog2(savestate_pkg::SS_WORDS32)-1:0] wr_ptr;
  logic [$clog2(savestate_pkg::SS_WORDS32)-1:0] rd_ptr;
  logic [$clog2(savestate_pkg::SS_WORDS32):0]   count;

  // Even SD word waiting for its partner
  logic [15:0] lo_hold;

  savestate_pkg::ss_word_u fifo_mem [savestate_pkg::SS_WORDS32];
  savestate_pkg::ss_word_u pair_word;

  logic accept;
  logic push;
  logic pop;

  // Host writes a whole block but only the savestate part is kept
  assign accept = load_active && sd_buff_wr &&
                  (sd_buff_addr < savestate_pkg::SS_WORDS16);

  assign push       = accept && sd_buff_addr[0];
  assign pop        = req_read && (count != '0);
  assign data_ready = (count != '0);

  // Odd word completes the pair
  always_comb begin
    pair_word.halves.hi = sd_buff_dout;
    pair_word.halves.lo = lo_hold;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end

      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end

      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept && !sd_buff_addr[0]) begin
      lo_hold <= sd_buff_dout;
    end

    if (push) begin
      fifo_mem[wr_ptr] <= pair_word;
    end

    // Head word appears the cycle after the strobe
    if (pop) begin
      bus_in <= fifo_mem[rd_ptr].full;
    end
  end

endmodule

`default_nettype wire

//--- design/sd_save_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module sd_save_buffer (
  input  wire                                   clk,
  input  wire                                   reset,
  input  wire                                   write_en,
  input  wire [31:0]                            bus_out,
  input  wire                                   save_active,
  input  wire [savestate_pkg::SD_ADDR_W-1:0]    sd_buff_addr,
  output logic [15:0]                           sd_buff_din,
  output logic                                  data_consumed
);

  // Number of words written since the last clear
  logic [$clog2(savestate_pkg::SS_WORDS32):0] fill_cnt;
  logic                                       active_q;

  savestate_pkg::ss_word_u buf_mem [savestate_pkg::SS_WORDS32];
  savestate_pkg::ss_word_u rd_word;

  logic store;
  logic active_fall;
  logic in_range;

  // Writes past the end of the state are dropped
  assign store       = write_en && (fill_cnt < savestate_pkg::SS_WORDS32);
  assign active_fall = active_q && !save_active;
  assign in_range    = (sd_buff_addr < savestate_pkg::SS_WORDS16);

  assign data_consumed = (fill_cnt == '0);

  // Two SD addresses share one stored word
  assign rd_word = buf_mem[sd_buff_addr[$clog2(savestate_pkg::SS_WORDS16)-1:1]];

  always_comb begin
    if (!in_range) begin
      sd_buff_din = 16'h0000;
    end else if (sd_buff_addr[0]) begin
      sd_buff_din = rd_word.halves.hi;
    end else begin
      sd_buff_din = rd_word.halves.lo;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      fill_cnt <= '0;
      active_q <= 1'b0;
    end else begin
      active_q <= save_active;

      // Host has read the block so the buffer is free again
      if (active_fall) begin
        fill_cnt <= '0;
      end else if (store) begin
        fill_cnt <= fill_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (store) begin
      buf_mem[fill_cnt[$clog2(savestate_pkg::SS_WORDS32)-1:0]].full <= bus_out;
    end
  end

endmodule

`default_nettype wire

//--- design/savestate_transfer_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module savestate_transfer_ctrl (
  input  wire  clk,
  input  wire  reset,
  input  wire  start_create,
  input  wire  start_load,
  input  wire  ss_ready,
  input  wire  sd_ack,
  output logic sd_wr,
  output logic sd_rd,
  output logic engine_create,
  output logic engine_load,
  output logic save_active,
  output logic load_active
);

  logic [savestate_pkg::CTRL_ST_W-1:0] state;

  logic ack_q;
  logic ack_rise;
  logic ack_fall;

  assign ack_rise = sd_ack && !ack_q;
  assign ack_fall = ack_q && !sd_ack;

  // Data phase of each access direction
  assign save_active = (state == savestate_pkg::CTRL_WRITING) && sd_ack;
  assign load_active = (state == savestate_pkg::CTRL_READING) && sd_ack;

  always_ff @(posedge clk) begin
    if (reset) begin
      state         <= savestate_pkg::CTRL_IDLE;
      ack_q         <= 1'b0;
      sd_wr         <= 1'b0;
      sd_rd         <= 1'b0;
      engine_create <= 1'b0;
      engine_load   <= 1'b0;
    end else begin
      ack_q <= sd_ack;

      // Engine starts are single-cycle
      engine_create <= 1'b0;
      engine_load   <= 1'b0;

      // Host took the request, drop it
      if (ack_rise) begin
        sd_wr <= 1'b0;
        sd_rd <= 1'b0;
      end

      case (state)
        savestate_pkg::CTRL_IDLE: begin
          // Create wins when both arrive together
          if (start_create) begin
            state         <= savestate_pkg::CTRL_WAIT_READY;
            engine_create <= 1'b1;
          end else if (start_load) begin
            state <= savestate_pkg::CTRL_READING;
            sd_rd <= 1'b1;
          end
        end

        savestate_pkg::CTRL_WAIT_READY: begin
          // Buffer holds the full state
          if (ss_ready) begin
            state <= savestate_pkg::CTRL_WRITING;
            sd_wr <= 1'b1;
          end
        end

        savestate_pkg::CTRL_WRITING: begin
          if (ack_fall) begin
            state <= savestate_pkg::CTRL_IDLE;
          end
        end

        savestate_pkg::CTRL_READING: begin
          // Block is in the packer, let the engine copy it
          if (ack_fall) begin
            state       <= savestate_pkg::CTRL_IDLE;
            engine_load <= 1'b1;
          end
        end

        default: begin
          state <= savestate_pkg::CTRL_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- design/savestate_engine.sv
`timescale 1ns/1ps
`default_nettype none

module savestate_engine (
  input  wire                                   clk,
  input  wire                                   reset,
  input  wire                                   engine_create,
  input  wire                                   engine_load,
  input  wire                                   data_consumed,
  input  wire                                   data_ready,
  input  wire [31:0]                            bus_in,
  input  wire                                   core_wr_en,
  input  wire [savestate_pkg::CORE_ADDR_W-1:0]  core_addr,
  input  wire [31:0]                            core_wdata,
  output logic                                  ss_ready,
  output logic                                  req_write,
  output logic [31:0]                           bus_out,
  output logic                                  req_read,
  output logic                                  ss_done,
  output logic [31:0]                           core_rdata
);

  logic [savestate_pkg::ENG_ST_W-1:0]    state;
  logic [savestate_pkg::CORE_ADDR_W-1:0] idx;

  // bus_in is valid the cycle after a read strobe
  logic rd_pending;
  logic last_idx;

  // Stand-in for the emulated core's machine state
  savestate_pkg::ss_word_u core_regs [savestate_pkg::SS_WORDS32];

  assign last_idx   = (idx == savestate_pkg::SS_WORDS32 - 1);
  assign core_rdata = core_regs[core_addr].full;

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= savestate_pkg::ENG_IDLE;
      idx        <= '0;
      rd_pending <= 1'b0;
      req_read   <= 1'b0;
      req_write  <= 1'b0;
      ss_ready   <= 1'b0;
      ss_done    <= 1'b0;
    end else begin
      ss_ready   <= 1'b0;
      ss_done    <= 1'b0;
      req_write  <= 1'b0;
      req_read   <= 1'b0;
      rd_pending <= req_read;

      case (state)
        savestate_pkg::ENG_IDLE: begin
          idx <= '0;
          if (engine_create) begin
            state <= savestate_pkg::ENG_CREATE_WAIT;
          end else if (engine_load) begin
            state <= savestate_pkg::ENG_LOAD;
          end
        end

        // Previous save must have left the buffer
        savestate_pkg::ENG_CREATE_WAIT: begin
          if (data_consumed) begin
            state <= savestate_pkg::ENG_CREATE;
          end
        end

        savestate_pkg::ENG_CREATE: begin
          req_write <= 1'b1;
          idx       <= idx + 1'b1;
          if (last_idx) begin
            state <= savestate_pkg::ENG_CREATE_END;
          end
        end

        // Last word lands in the buffer on this edge
        savestate_pkg::ENG_CREATE_END: begin
          ss_ready <= 1'b1;
          state    <= savestate_pkg::ENG_IDLE;
        end

        savestate_pkg::ENG_LOAD: begin
          // One read in flight so data_ready is never stale
          if (data_ready && !req_read) begin
            req_read <= 1'b1;
          end

          if (rd_pending) begin
            idx <= idx + 1'b1;
            if (last_idx) begin
              ss_done <= 1'b1;
              state   <= savestate_pkg::ENG_IDLE;
            end
          end
        end

        default: begin
          state <= savestate_pkg::ENG_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == savestate_pkg::ENG_CREATE) begin
      bus_out <= core_regs[idx].full;
    end

    // Outside access only while the engine is idle
    if ((state == savestate_pkg::ENG_LOAD) && rd_pending) begin
      core_regs[idx].full <= bus_in;
    end else if ((state == savestate_pkg::ENG_IDLE) && core_wr_en) begin
      core_regs[core_addr].full <= core_wdata;
    end
  end

endmodule

`default_nettype wire

//--- design/savestate_top.sv
`timescale 1ns/1ps
`default_nettype none

module savestate_top (
  input  wire                                   clk,
  input  wire                                   reset,
  input  wire                                   start_create,
  input  wire                                   start_load,
  input  wire                                   sd_ack,
  input  wire [savestate_pkg::SD_ADDR_W-1:0]    sd_buff_addr,
  input  wire [15:0]                            sd_buff_dout,
  input  wire                                   sd_buff_wr,
  input  wire                                   core_wr_en,
  input  wire [savestate_pkg::CORE_ADDR_W-1:0]  core_addr,
  input  wire [31:0]                            core_wdata,
  output logic                                  sd_wr,
  output logic                                  sd_rd,
  output logic [15:0]                           sd_buff_din,
  output logic                                  ss_done,
  output logic [31:0]                           core_rdata
);

  // Controller to engine
  logic engine_create;
  logic engine_load;
  logic ss_ready;

  // SD data phases
  logic save_active;
  logic load_active;

  // Load path
  logic        data_ready;
  logic        req_read;
  logic [31:0] bus_in;

  // Save path
  logic        data_consumed;
  logic        req_write;
  logic [31:0] bus_out;

  savestate_transfer_ctrl u_ctrl (
    .clk           (clk),
    .reset         (reset),
    .start_create  (start_create),
    .start_load    (start_load),
    .ss_ready      (ss_ready),
    .sd_ack        (sd_ack),
    .sd_wr         (sd_wr),
    .sd_rd         (sd_rd),
    .engine_create (engine_create),
    .engine_load   (engine_load),
    .save_active   (save_active),
    .load_active   (load_active)
  );

  sd_load_packer u_packer (
    .clk          (clk),
    .reset        (reset),
    .load_active  (load_active),
    .sd_buff_wr   (sd_buff_wr),
    .sd_buff_addr (sd_buff_addr),
    .sd_buff_dout (sd_buff_dout),
    .req_read     (req_read),
    .data_ready   (data_ready),
    .bus_in       (bus_in)
  );

  sd_save_buffer u_save_buf (
    .clk           (clk),
    .reset         (reset),
    .write_en      (req_write),
    .bus_out       (bus_out),
    .save_active   (save_active),
    .sd_buff_addr  (sd_buff_addr),
    .sd_buff_din   (sd_buff_din),
    .data_consumed (data_consumed)
  );

  savestate_engine u_engine (
    .clk           (clk),
    .reset         (reset),
    .engine_create (engine_create),
    .engine_load   (engine_load),
    .data_consumed (data_consumed),
    .data_ready    (data_ready),
    .bus_in        (bus_in),
    .core_wr_en    (core_wr_en),
    .core_addr     (core_addr),
    .core_wdata    (core_wdata),
    .ss_ready      (ss_ready),
    .req_write     (req_write),
    .bus_out       (bus_out),
    .req_read      (req_read),
    .ss_done       (ss_done),
    .core_rdata    (core_rdata)
  );

endmodule

`default_nettype wire

//--- dv/savestate_assert.sv
`timescale 1ns/1ps
`default_nettype none

module savestate_assert (
  input wire clk,
  input wire reset,
  input wire sd_wr,
  input wire sd_rd,
  input wire engine_create,
  input wire engine_load,
  input wire ss_ready
);

  // Failure count, read by the testbench at the end of the run
  int err_cnt = 0;

  // One SD direction at a time
  sd_dir_excl: assert property (@(posedge clk) disable iff (reset) !(sd_wr && sd_rd))
    else begin
      $error("sd_wr and sd_rd high together");
      err_cnt++;
    end

  create_one_cycle: assert property (@(posedge clk) disable iff (reset)
    engine_create |=> !engine_create)
    else begin
      $error("engine_create longer than one cycle");
      err_cnt++;
    end

  load_one_cycle: assert property (@(posedge clk) disable iff (reset)
    engine_load |=> !engine_load)
    else begin
      $error("engine_load longer than one cycle");
      err_cnt++;
    end

  // Save request follows the engine's ready pulse
  wr_after_ready: assert property (@(posedge clk) disable iff (reset)
    $rose(sd_wr) |-> $past(ss_ready))
    else begin
      $error("sd_wr rose without ss_ready");
      err_cnt++;
    end

endmodule

bind savestate_transfer_ctrl savestate_assert u_assert (
  .clk           (clk),
  .reset         (reset),
  .sd_wr         (sd_wr),
  .sd_rd         (sd_rd),
  .engine_create (engine_create),
  .engine_load   (engine_load),
  .ss_ready      (ss_ready)
);

`default_nettype wire

//--- dv/savestate_tb.sv
`timescale 1ns/1ps
`default_nettype none

module savestate_tb;

  localparam int N_TESTS   = 6;
  localparam int OP_CREATE = 0;
  localparam int OP_LOAD   = 1;
  localparam int OP_BUSY   = 2;
  localparam int N_REGS    = savestate_pkg::SS_WORDS32;
  localparam int N_WORDS   = savestate_pkg::SS_WORDS16;
  localparam int N_BLOCK   = savestate_pkg::BLOCK_WORDS;
  localparam int CYCLE_LIMIT = N_TESTS * (2 * N_BLOCK + 64);

  logic                                  clk;
  logic                                  reset;
  logic                                  start_create;
  logic                                  start_load;
  logic                                  sd_ack;
  logic [savestate_pkg::SD_ADDR_W-1:0]   sd_buff_addr;
  logic [15:0]                           sd_buff_dout;
  logic                                  sd_buff_wr;
  logic                                  core_wr_en;
  logic [savestate_pkg::CORE_ADDR_W-1:0] core_addr;
  logic [31:0]                           core_wdata;
  logic                                  sd_wr;
  logic                                  sd_rd;
  logic [15:0]                           sd_buff_din;
  logic                                  ss_done;
  logic [31:0]                           core_rdata;

  // Stimulus table
  int          tbl_op   [N_TESTS];
  logic [31:0] tbl_core [N_TESTS][N_REGS];
  logic [15:0] tbl_sd   [N_TESTS][N_WORDS];

  // Words the host writes on a load, or expects to read on a save
  logic [15:0] host_words [N_BLOCK];

  logic [31:0] lcg_state;
  int          test_errs;
  int          pass_cnt;
  int          fail_cnt;
  int          cycle_cnt;

  savestate_top dut (
    .clk          (clk),
    .reset        (reset),
    .start_create (start_create),
    .start_load   (start_load),
    .sd_ack       (sd_ack),
    .sd_buff_addr (sd_buff_addr),
    .sd_buff_dout (sd_buff_dout),
    .sd_buff_wr   (sd_buff_wr),
    .core_wr_en   (core_wr_en),
    .core_addr    (core_addr),
    .core_wdata   (core_wdata),
    .sd_wr        (sd_wr),
    .sd_rd        (sd_rd),
    .sd_buff_din  (sd_buff_din),
    .ss_done      (ss_done),
    .core_rdata   (core_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic flag_error(input string msg);
    $display("[FAIL] %0t: %s", $time, msg);
    test_errs++;
  endtask

  task automatic watch_idle(input int n);
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      if (sd_wr || sd_rd) begin
        flag_error("SD request without a trigger");
      end
    end
  endtask

  task automatic pulse_trigger(input bit create);
    @(posedge clk);
    if (create) begin
      start_create <= 1'b1;
    end else begin
      start_load <= 1'b1;
    end
    @(posedge clk);
    start_create <= 1'b0;
    start_load   <= 1'b0;
  endtask

  task automatic write_core(input int t);
    for (int i = 0; i < N_REGS; i++) begin
      @(posedge clk);
      core_wr_en <= 1'b1;
      core_addr  <= i[savestate_pkg::CORE_ADDR_W-1:0];
      core_wdata <= tbl_core[t][i];
    end
    @(posedge clk);
    core_wr_en <= 1'b0;
  endtask

  task automatic check_core(input int i, input logic [31:0] expected);
    @(posedge clk);
    core_addr <= i[savestate_pkg::CORE_ADDR_W-1:0];
    @(negedge clk);
    if (core_rdata !== expected) begin
      flag_error($sformatf("core reg %0d is %h, expected %h", i, core_rdata, expected));
    end
  endtask

  // SD host model for one block access with an optional start_load midway
  task automatic host_access(input bit is_load, input bit poke_load);
    @(negedge clk);
    while (!sd_wr && !sd_rd) begin
      @(negedge clk);
    end
    if ((sd_rd !== is_load) || (sd_wr !== !is_load)) begin
      flag_error($sformatf("wrong SD request, sd_wr %b sd_rd %b", sd_wr, sd_rd));
    end
    for (int a = 0; a < N_BLOCK; a++) begin
      @(posedge clk);
      sd_ack       <= 1'b1;
      sd_buff_addr <= a[savestate_pkg::SD_ADDR_W-1:0];
      sd_buff_wr   <= is_load;
      sd_buff_dout <= is_load ? host_words[a] : 16'h0000;
      start_load   <= poke_load && (a == 8);
      if (!is_load) begin
        @(negedge clk);
        if (sd_buff_din !== host_words[a]) begin
          flag_error($sformatf("SD addr %0d read %h, expected %h",
                               a, sd_buff_din, host_words[a]));
        end
      end
    end
    @(posedge clk);
    sd_ack     <= 1'b0;
    sd_buff_wr <= 1'b0;
    start_load <= 1'b0;
  endtask

  task automatic run_test(input int t);
    if (tbl_op[t] == OP_LOAD) begin
      // Filler past the savestate must be dropped
      for (int a = 0; a < N_BLOCK; a++) begin
        lcg_state = lcg_next(lcg_state);
        host_words[a] = (a < N_WORDS) ? tbl_sd[t][a] : lcg_state[31:16];
      end
      pulse_trigger(1'b0);
      host_access(1'b1, 1'b0);
      @(negedge clk);
      while (!ss_done) begin
        @(negedge clk);
      end
      for (int i = 0; i < N_REGS; i++) begin
        check_core(i, {tbl_sd[t][2 * i + 1], tbl_sd[t][2 * i]});
      end
      // Round trip back to the SD side
      for (int a = 0; a < N_BLOCK; a++) begin
        host_words[a] = (a < N_WORDS) ? tbl_sd[t][a] : 16'h0000;
      end
      pulse_trigger(1'b1);
      host_access(1'b0, 1'b0);
    end else begin
      write_core(t);
      for (int a = 0; a < N_BLOCK; a++) begin
        if (a >= N_WORDS) begin
          host_words[a] = 16'h0000;
        end else if (a % 2 == 1) begin
          host_words[a] = tbl_core[t][a / 2][31:16];
        end else begin
          host_words[a] = tbl_core[t][a / 2][15:0];
        end
      end
      pulse_trigger(1'b1);
      if (tbl_op[t] == OP_BUSY) begin
        repeat (2) @(posedge clk);
        pulse_trigger(1'b0);
      end
      host_access(1'b0, tbl_op[t] == OP_BUSY);
    end
    watch_idle(8);
  endtask

  task automatic log_result(input int t, input string name);
    if (test_errs == 0) begin
      pass_cnt++;
      $display("Test %0d %s: PASS", t, name);
    end else begin
      fail_cnt++;
      $display("Test %0d %s: FAIL with %0d errors", t, name, test_errs);
    end
  endtask

  initial begin
    reset        = 1'b1;
    start_create = 1'b0;
    start_load   = 1'b0;
    sd_ack       = 1'b0;
    sd_buff_addr = '0;
    sd_buff_dout = 16'h0000;
    sd_buff_wr   = 1'b0;
    core_wr_en   = 1'b0;
    core_addr    = '0;
    core_wdata   = 32'h0;
    lcg_state    = 32'he3cb;
    pass_cnt     = 0;
    fail_cnt     = 0;

    tbl_op[0] = OP_CREATE;
    tbl_op[1] = OP_LOAD;
    tbl_op[2] = OP_BUSY;
    tbl_op[3] = OP_LOAD;
    tbl_op[4] = OP_BUSY;
    tbl_op[5] = OP_CREATE;
    for (int t = 0; t < N_TESTS; t++) begin
      for (int i = 0; i < N_REGS; i++) begin
        lcg_state = lcg_next(lcg_state);
        tbl_core[t][i] = lcg_state;
      end
      for (int w = 0; w < N_WORDS; w++) begin
        lcg_state = lcg_next(lcg_state);
        tbl_sd[t][w] = lcg_state[31:16];
      end
    end

    repeat (8) @(posedge clk);
    reset <= 1'b0;

    test_errs = 0;
    @(negedge clk);
    if (sd_wr || sd_rd || ss_done) begin
      flag_error("outputs not low after reset");
    end
    watch_idle(16);
    log_result(0, "reset");

    for (int t = 0; t < N_TESTS; t++) begin
      test_errs = 0;
      run_test(t);
      log_result(t + 1, (tbl_op[t] == OP_LOAD) ? "load" :
                        (tbl_op[t] == OP_BUSY) ? "busy-trigger" : "create");
    end

    $display("Summary: %0d passed, %0d failed, %0d assertion errors",
             pass_cnt, fail_cnt, dut.u_ctrl.u_assert.err_cnt);
    if ((fail_cnt == 0) && (dut.u_ctrl.u_assert.err_cnt == 0)) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Run length limit
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
    $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
design/savestate_pkg.sv
design/sd_load_packer.sv
design/sd_save_buffer.sv
design/savestate_transfer_ctrl.sv
design/savestate_engine.sv
design/savestate_top.sv
dv/savestate_assert.sv
dv/savestate_tb.sv
